//--- Makefile
TOP := tb_eeprom_master
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir $(LOG)

//--- bench/i2c_eeprom_model.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_eeprom_model
    import eeprom_pkg::*;
(
    input  wire  scl,
    inout  wire  sda,
    output logic proto_err
);

    localparam int BUSY_EDGES = 40;  // internal write cycle, in scl rising edges

    typedef enum logic [2:0] {ST_IDLE, ST_CTRL, ST_ADDR, ST_WDATA, ST_RDATA, ST_IGNORE} state_t;

    logic [7:0]         mem [0:(1 << ADDR_W)-1];
    state_t             state = ST_IDLE;
    logic [7:0]         rx;
    logic [7:0]         tx;
    logic [BLOCK_W-1:0] block;
    logic [7:0]         word;
    logic [7:0]         wbuf;
    logic               have_data = 1'b0;
    logic               acked = 1'b0;
    logic               rd_mode;
    logic               drive_low = 1'b0;
    logic               bad_code = 1'b0;
    logic               scl_q = 1'b1;
    logic               sda_q = 1'b1;
    int                 bits = 0;
    int                 busy_cnt = 0;

    assign sda       = drive_low ? 1'b0 : 1'bz;
    assign proto_err = bad_code;

    initial
    begin
        for (int a = 0; a < (1 << ADDR_W); a++)
            mem[a] = 8'(a) ^ {5'b0, 3'(a >> 8)};
    end

    always @(scl or sda)
    begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q)
        begin
            if (sda === 1'b0)
                state = ST_CTRL;  // start or repeated start
            else
            begin
                if (have_data)
                begin
                    mem[{block, word}] = wbuf;
                    busy_cnt = BUSY_EDGES;
                end
                state = ST_IDLE;
            end
            bits = 0;
            have_data = 1'b0;
            drive_low = 1'b0;
        end
        else if (scl === 1'b1 && scl_q === 1'b0)
        begin
            if (busy_cnt > 0)
                busy_cnt--;
            if (state != ST_IDLE && state != ST_IGNORE)
            begin
                if (bits < 8)
                    rx = {rx[6:0], sda};
                bits++;
            end
        end
        else if (scl === 1'b0 && scl_q === 1'b1 && state != ST_IDLE && state != ST_IGNORE)
        begin
            if (bits == 8)
            begin
                acked = (state != ST_RDATA) &&
                        !(state == ST_CTRL && (busy_cnt > 0 || rx[7:4] != EEPROM_DEV_CODE));
                case (state)
                    ST_CTRL:
                    begin
                        bad_code = bad_code | (rx[7:4] != EEPROM_DEV_CODE);
                        block = rx[3:1];
                        rd_mode = rx[0];
                    end
                    ST_ADDR:
                        word = rx;
                    ST_WDATA:
                    begin
                        wbuf = rx;
                        have_data = 1'b1;
                    end
                    default:
                        ;
                endcase
                drive_low = acked;  // released for the master ack on a read
            end
            else if (bits == 9)
            begin
                bits = 0;
                drive_low = 1'b0;
                if (state == ST_CTRL && acked && rd_mode)
                begin
                    state = ST_RDATA;
                    tx = mem[{block, word}];
                    drive_low = !tx[7];
                end
                else if (state == ST_CTRL && acked)
                    state = ST_ADDR;
                else if (state == ST_ADDR)
                    state = ST_WDATA;
                else
                    state = ST_IGNORE;
            end
            else if (state == ST_RDATA)
                drive_low = !tx[7 - bits];
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

`default_nettype wire

//--- bench/tb_eeprom_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_master
    import eeprom_pkg::*;
();

    localparam int ACK_TIMEOUT = 1000;  // CLK cycles for one request
    localparam int MAX_TRIES   = 8;

    logic              CLK = 1'b0;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    wire  [7:0]        rdata;
    wire               ack;
    wire               nack;
    wire               busy;
    wire               scl;
    wire               sda;
    wire               proto_err;
    logic [31:0]       lfsr = 32'h09369410;
    logic [7:0]        shadow [0:(1 << ADDR_W)-1];
    logic [7:0]        last_rdata;

    pullup (scl);
    pullup (sda);

    eeprom_master i_dut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .ack(ack), .nack(nack), .busy(busy), .scl(scl), .sda(sda)
    );

    i2c_eeprom_model i_eeprom (.scl(scl), .sda(sda), .proto_err(proto_err));

    always #10 CLK = ~CLK;

    always @(posedge proto_err)
        abort_run("EEPROM model received a control byte without device code 1010");

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare(input logic [31:0] got, input logic [31:0] expected,
                           input string what);
        if (got !== expected)
            abort_run($sformatf("Fail at %0t ns: %s, got %0h, expected %0h",
                                $time, what, got, expected));
    endtask

    // right shifting galois form
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_idle();
        compare(32'(ack), 0, "ack while idle");
        compare(32'(nack), 0, "nack while idle");
        compare(32'(busy), 0, "busy while idle");
        compare(32'(scl), 1, "scl released while idle");
        compare(32'(sda), 1, "sda released while idle");
    endtask

    // runs one request and hands back the nack flag and read data
    task automatic request(input logic write, input logic [ADDR_W-1:0] a, input logic [7:0] d,
                           output logic refused, output logic [7:0] data);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        #1;
        wr = write;
        rd = !write;
        addr = a;
        wdata = d;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        @(negedge CLK);
        while (!ack)
        begin
            if (cycles == ACK_TIMEOUT)
                abort_run("timeout, the DUT gave no ack for a request");
            compare(32'(busy), 1, "busy while a request runs");
            compare(32'(rdata), 32'(last_rdata), "rdata held before ack");
            cycles++;
            @(negedge CLK);
        end
        compare(32'(busy), 1, "busy with ack");
        refused = nack;
        data = rdata;
        if (write || nack)
            compare(32'(rdata), 32'(last_rdata), "rdata held on ack");
        last_rdata = rdata;
        @(negedge CLK);
        check_idle();  // ack is a single cycle
    endtask

    task automatic retry_until_accepted(input logic write, input logic [ADDR_W-1:0] a,
                                        input logic [7:0] d);
        logic       refused;
        logic [7:0] data;
        int         tries;
        refused = 1'b1;
        tries = 0;
        while (refused)
        begin
            if (tries == MAX_TRIES)
                abort_run("EEPROM kept refusing a request after many retries");
            tries++;
            request(write, a, d, refused, data);
        end
        if (write)
            shadow[a] = d;
        else
            compare(32'(data), 32'(shadow[a]), "read data against shadow");
    endtask

    initial
    begin
        logic [31:0]       r;
        logic [31:0]       d;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] a2;
        logic              refused;
        logic [7:0]        data;
        RESET = 1'b1;
        wr = 1'b0;
        rd = 1'b0;
        addr = '0;
        wdata = '0;
        last_rdata = 8'h00;
        for (int i = 0; i < (1 << ADDR_W); i++)
            shadow[i] = 8'(i) ^ {5'b0, 3'(i >> 8)};
        repeat (2) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        check_idle();
        for (int n = 0; n < 10; n++)
        begin
            random_bits(ADDR_W, r);
            request(1'b0, r[ADDR_W-1:0], 8'h00, refused, data);
            compare(32'(refused), 0, "nack on a fresh read");
            compare(32'(data), 32'(shadow[r[ADDR_W-1:0]]), "initial contents");
        end
        for (int n = 0; n < 12; n++)
        begin
            random_bits(ADDR_W, r);
            random_bits(19, d);
            a = r[ADDR_W-1:0];
            // same word byte in another block
            a2 = {a[ADDR_W-1 -: BLOCK_W] ^ ((d[18:16] == 3'b000) ? 3'b100 : d[18:16]), a[7:0]};
            retry_until_accepted(1'b1, a, d[7:0]);
            retry_until_accepted(1'b1, a2, d[15:8]);
            request(1'b1, a, ~d[7:0], refused, data);
            compare(32'(refused), 1, "write during the busy window");
            retry_until_accepted(1'b0, a, 8'h00);
            retry_until_accepted(1'b0, a2, 8'h00);
            // random operation on a random address
            random_bits(ADDR_W, r);
            random_bits(9, d);
            retry_until_accepted(d[8], r[ADDR_W-1:0], d[7:0]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/eeprom_master.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_master
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              wr,
    input  wire logic              rd,
    input  wire logic [ADDR_W-1:0] addr,
    input  wire logic [7:0]        wdata,
    output wire logic [7:0]        rdata,
    output wire logic              ack,
    output wire logic              nack,
    output wire logic              busy,
    output wire                    scl,
    inout  wire                    sda
);

    eeprom_req_t req;
    i2c_cmd_t    cmd;
    i2c_rsp_t    rsp;
    logic        cmd_strobe;
    logic        engine_idle;
    logic        done;
    logic        scl_low;
    logic        sda_low;

    assign req = '{addr: addr, wdata: wdata};

    // open drain, pull-ups are off chip
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

    eeprom_sequencer i_sequencer (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .req(req),
        .engine_idle(engine_idle), .done(done), .rsp(rsp),
        .cmd_strobe(cmd_strobe), .cmd(cmd),
        .rdata(rdata), .ack(ack), .nack(nack), .busy(busy)
    );

    i2c_bit_engine i_bit_engine (
        .CLK(CLK), .RESET(RESET), .cmd_strobe(cmd_strobe), .cmd(cmd),
        .sda_in(sda),
        .engine_idle(engine_idle), .done(done), .rsp(rsp),
        .scl_low(scl_low), .sda_low(sda_low)
    );

endmodule

`default_nettype wire

//--- src/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // 24C16 style device, 2 KB
    localparam logic [3:0] EEPROM_DEV_CODE = 4'b1010;

    localparam int ADDR_W  = 11;
    localparam int BLOCK_W = 3;   // upper address bits, sent in the control byte

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

endpackage

`default_nettype wire

//--- src/eeprom_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer
    import i2c_pkg::*;
    import eeprom_pkg::*;
(
    input  wire logic        CLK,
    input  wire logic        RESET,
    input  wire logic        wr,
    input  wire logic        rd,
    input  wire eeprom_req_t req,
    input  wire logic        engine_idle,
    input  wire logic        done,
    input  wire i2c_rsp_t    rsp,
    output logic             cmd_strobe,
    output i2c_cmd_t         cmd,
    output logic [7:0]       rdata,
    output logic             ack,
    output logic             nack,
    output logic             busy
);

    typedef enum logic [9:0] {
        S_IDLE     = 10'b00_0000_0001,
        S_START    = 10'b00_0000_0010,
        S_CTRL_WR  = 10'b00_0000_0100,
        S_ADDR_WR  = 10'b00_0000_1000,
        S_DATA_WR  = 10'b00_0001_0000,
        S_RD_START = 10'b00_0010_0000,
        S_CTRL_RD  = 10'b00_0100_0000,
        S_DATA_RD  = 10'b00_1000_0000,
        S_STOP     = 10'b01_0000_0000,
        S_DONE     = 10'b10_0000_0000
    } state_t;

    state_t             state;
    eeprom_req_t        req_q;
    logic               is_rd;
    logic               err;       // sticky, some byte was not acked
    logic               pending;   // command out, waiting for done
    logic [7:0]         rd_byte;
    logic [BLOCK_W-1:0] block;
    logic               issue_state;
    logic               no_ack;
    i2c_cmd_t           next_cmd;

    assign block       = req_q.addr[ADDR_W-1 -: BLOCK_W];
    assign issue_state = !(state inside {S_IDLE, S_DONE});
    assign no_ack      = !rsp.slave_ack;

    always_comb
    begin
        next_cmd = '{op: OP_START, tx_byte: 8'h00, ack_level: 1'b1};
        case (state)
            S_CTRL_WR:
                next_cmd = '{op: OP_WRITE, tx_byte: {EEPROM_DEV_CODE, block, 1'b0},
                             ack_level: 1'b1};
            S_ADDR_WR:
                next_cmd = '{op: OP_WRITE, tx_byte: req_q.addr[ADDR_W-BLOCK_W-1:0],
                             ack_level: 1'b1};
            S_DATA_WR:
                next_cmd = '{op: OP_WRITE, tx_byte: req_q.wdata, ack_level: 1'b1};
            S_CTRL_RD:
                next_cmd = '{op: OP_WRITE, tx_byte: {EEPROM_DEV_CODE, block, 1'b1},
                             ack_level: 1'b1};
            S_DATA_RD:
                next_cmd = '{op: OP_READ, tx_byte: 8'hff, ack_level: 1'b1};  // single byte, nack
            S_STOP:
                next_cmd.op = OP_STOP;
            default:
                next_cmd.op = OP_START;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= S_IDLE;
            cmd_strobe <= 1'b0;
            pending    <= 1'b0;
            is_rd      <= 1'b0;
            err        <= 1'b0;
            ack        <= 1'b0;
            nack       <= 1'b0;
            busy       <= 1'b0;
            rdata      <= 8'h00;
        end
        else
        begin
            cmd_strobe <= 1'b0;
            if (issue_state && !pending && engine_idle)
            begin
                cmd_strobe <= 1'b1;
                pending    <= 1'b1;
            end
            if (done)
                pending <= 1'b0;

            case (state)
                S_IDLE:
                    if (wr || rd)
                    begin
                        is_rd <= !wr;   // write wins
                        err   <= 1'b0;
                        busy  <= 1'b1;
                        state <= S_START;
                    end
                S_START:
                    if (done)
                        state <= S_CTRL_WR;
                S_CTRL_WR, S_ADDR_WR, S_DATA_WR, S_CTRL_RD:
                    if (done)
                    begin
                        if (no_ack || state == S_DATA_WR)
                        begin
                            err   <= err | no_ack;
                            state <= S_STOP;
                        end
                        else if (state == S_CTRL_WR)
                            state <= S_ADDR_WR;
                        else if (state == S_CTRL_RD)
                            state <= S_DATA_RD;
                        else
                            state <= is_rd ? S_RD_START : S_DATA_WR;
                    end
                S_RD_START:
                    if (done)
                        state <= S_CTRL_RD;
                S_DATA_RD:
                    if (done)
                        state <= S_STOP;
                S_STOP:
                    if (done)
                    begin
                        ack  <= 1'b1;
                        nack <= err;
                        if (is_rd && !err)
                            rdata <= rd_byte;
                        state <= S_DONE;
                    end
                S_DONE:
                begin
                    ack   <= 1'b0;
                    nack  <= 1'b0;
                    busy  <= 1'b0;
                    state <= S_IDLE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && (wr || rd))
            req_q <= req;
        if (issue_state && !pending && engine_idle)
            cmd <= next_cmd;
        if (state == S_DATA_RD && done)
            rd_byte <= rsp.rx_byte;
    end

    assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack);
    assert property (@(posedge CLK) disable iff (RESET) nack |-> ack);

endmodule

`default_nettype wire

//--- src/i2c_bit_engine.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
    import i2c_pkg::*;
(
    input  wire logic     CLK,
    input  wire logic     RESET,
    input  wire logic     cmd_strobe,
    input  wire i2c_cmd_t cmd,
    input  wire logic     sda_in,
    output logic          engine_idle,
    output logic          done,
    output i2c_rsp_t      rsp,
    output logic          scl_low,
    output logic          sda_low
);

    i2c_cmd_t          cur;
    logic              active;
    logic              clk_run;   // scl has been started and not yet stopped
    logic [QCNT_W-1:0] qcnt;
    logic [1:0]        qtr;       // quarter within the bit slot
    logic [3:0]        bcnt;
    logic [7:0]        sh;
    logic              ack_smp;
    logic              tick;
    logic              is_byte;
    logic              ninth;
    logic              last_qtr;

    assign tick     = active && (qcnt == QCNT_W'(SCL_QUARTER - 1));
    assign is_byte  = (cur.op == OP_WRITE) || (cur.op == OP_READ);
    assign ninth    = (bcnt == 4'(BYTE_BITS - 1));
    assign last_qtr = (qtr == 2'd3) && (!is_byte || ninth);

    assign engine_idle = !active;
    assign rsp         = '{rx_byte: sh, slave_ack: ack_smp};

    // bit slot: q0 scl low, q1 data, q2 scl high, q3 hold (start/stop move sda here)
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            done    <= 1'b0;
            clk_run <= 1'b0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
            qcnt    <= '0;
            qtr     <= 2'd0;
            bcnt    <= 4'd0;
        end
        else
        begin
            done <= 1'b0;
            if (cmd_strobe && !active)
            begin
                active  <= 1'b1;
                qcnt    <= '0;
                qtr     <= 2'd0;
                bcnt    <= 4'd0;
                scl_low <= (cmd.op != OP_START) || clk_run;  // idle start keeps scl high
            end
            else if (active)
            begin
                qcnt <= tick ? '0 : qcnt + 1'b1;
                if (tick)
                begin
                    if (last_qtr)
                    begin
                        active <= 1'b0;
                        done   <= 1'b1;
                        if (cur.op == OP_START)
                            clk_run <= 1'b1;
                        else if (cur.op == OP_STOP)
                            clk_run <= 1'b0;   // bus stays released after stop
                    end
                    else if (qtr == 2'd3)
                    begin
                        qtr     <= 2'd0;
                        bcnt    <= bcnt + 4'd1;
                        scl_low <= 1'b1;
                    end
                    else
                    begin
                        qtr <= qtr + 2'd1;
                        case (qtr)
                            2'd0:
                            begin
                                case (cur.op)
                                    OP_START: sda_low <= 1'b0;
                                    OP_STOP:  sda_low <= 1'b1;
                                    OP_WRITE: sda_low <= ninth ? 1'b0 : !sh[7];
                                    default:  sda_low <= ninth ? !cur.ack_level : 1'b0;
                                endcase
                            end
                            2'd1:
                                scl_low <= 1'b0;
                            default:
                            begin
                                if (cur.op == OP_START)
                                    sda_low <= 1'b1;   // sda falls with scl high
                                else if (cur.op == OP_STOP)
                                    sda_low <= 1'b0;
                            end
                        endcase
                    end
                end
            end
        end
    end

    // shared shifter, tx bits leave at the top while rx bits enter at the bottom
    always_ff @(posedge CLK)
    begin
        if (cmd_strobe && !active)
        begin
            cur <= cmd;
            sh  <= cmd.tx_byte;
        end
        else if (tick && qtr == 2'd2 && is_byte)
        begin
            if (ninth)
                ack_smp <= !sda_in;   // sampled mid scl high
            else
                sh <= {sh[6:0], sda_in};
        end
    end

    // sequencer must wait for the engine
    assert property (@(posedge CLK) disable iff (RESET) cmd_strobe |-> engine_idle);

    // data only moves while scl is low, apart from start and stop
    assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_low) && !scl_low && !$past(scl_low))
            |-> (cur.op == OP_START || cur.op == OP_STOP));

endmodule

`default_nettype wire

//--- src/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    localparam int SCL_QUARTER = 2;   // CLK cycles per quarter of SCL
    localparam int QCNT_W = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;
    localparam int BYTE_BITS = 9;     // eight data bits plus ack

    typedef enum logic [1:0] {
        OP_START = 2'd0,  // also repeated start when scl is running
        OP_STOP  = 2'd1,
        OP_WRITE = 2'd2,
        OP_READ  = 2'd3
    } i2c_op_t;

    typedef struct packed {
        i2c_op_t    op;
        logic [7:0] tx_byte;
        logic       ack_level;  // sda level on ninth bit of a read, 1 = nack
    } i2c_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_ack;
    } i2c_rsp_t;

endpackage

`default_nettype wire

//--- verilog.f
src/i2c_pkg.sv
src/eeprom_pkg.sv
src/i2c_bit_engine.sv
src/eeprom_sequencer.sv
src/eeprom_master.sv
bench/i2c_eeprom_model.sv
bench/tb_eeprom_master.sv
